// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_rv32_core \
    -f rv32_core.f -o vsim_rv32_core

out=$(./obj_dir/vsim_rv32_core)
echo "$out"

if echo "$out" | grep -q -x -F "** PASS **"; then
    exit 0
fi
exit 1

// File: rv32_core.f
+incdir+source
source/rv32_pkg.sv
source/div_if.sv
source/rv32_decode.sv
source/rv32_regfile.sv
source/rv32_execute.sv
source/rv32_divider.sv
source/rv32_core.sv
sim/tb_rv32_core.sv

// File: sim/tb_rv32_core.sv
`timescale 1ns/100ps
`include "rv32_cfg.svh"

module tb_rv32_core;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_INST = 40;    // covers the slowest divide
    localparam logic [31:0] STORE_BASE = 32'h0000_0100;

    logic        clk;
    logic        clrn;
    logic [31:0] i_inst;
    logic [31:0] i_mem;
    logic [31:0] o_pc;
    logic [31:0] o_alu_out;
    logic [31:0] o_b;
    logic        o_wmem;

    logic [31:0] imem [0:511];
    logic [31:0] dmem [0:255];
    logic [31:0] mreg [0:31];               // reference register file
    logic [31:0] trace [$];                 // pcs in execution order
    logic [31:0] exp_val [$];
    logic [31:0] exp_addr [$];
    string       exp_name [$];
    integer      seed;
    int          wp;
    int          idx;
    int          sidx;
    int          stay;
    int          errors;
    int          checks;
    logic [31:0] last_pc;
    logic [31:0] halt_pc;
    logic        last_was_div;
    logic        built;
    logic        done;

    rv32_core UUT (
        .clk(clk), .clrn(clrn), .i_inst(i_inst), .i_mem(i_mem),
        .o_pc(o_pc), .o_alu_out(o_alu_out), .o_b(o_b), .o_wmem(o_wmem)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign i_inst = imem[o_pc[10:2]];
    assign i_mem  = dmem[o_alu_out[9:2]];

    always @(posedge clk) begin
        if (clrn && o_wmem) dmem[o_alu_out[9:2]] <= o_b;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        enc_i = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        enc_s = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic is_div(input logic [31:0] inst);
        is_div = (inst[6:0] == 7'b0110011) && (inst[31:25] == 7'd1) && inst[14];
    endfunction

    // RV32I result of an OP or OP-IMM funct3
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'b000:  alu_ref = alt ? a - b : a + b;
            3'b001:  alu_ref = a << b[4:0];
            3'b010:  alu_ref = {31'd0, sa < sb};
            3'b011:  alu_ref = {31'd0, a < b};
            3'b100:  alu_ref = a ^ b;
            3'b101: begin
                if (alt) alu_ref = sa >>> b[4:0];
                else alu_ref = a >> b[4:0];
            end
            3'b110:  alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    // RV32M divide rules, zero divisor and overflow included
    function automatic logic [31:0] div_ref(input logic [2:0] f3,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            3'b100: begin
                if (b == 0) div_ref = 32'hffff_ffff;
                else if (ovf) div_ref = a;
                else div_ref = sa / sb;
            end
            3'b101:  div_ref = (b == 0) ? 32'hffff_ffff : a / b;
            3'b110: begin
                if (b == 0) div_ref = a;
                else if (ovf) div_ref = 32'd0;
                else div_ref = sa % sb;
            end
            default: div_ref = (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'b000:  taken_ref = (a == b);
            3'b001:  taken_ref = (a != b);
            3'b100:  taken_ref = ($signed(a) < $signed(b));
            3'b101:  taken_ref = ($signed(a) >= $signed(b));
            3'b110:  taken_ref = (a < b);
            default: taken_ref = (a >= b);
        endcase
    endfunction

    task automatic put(input logic [31:0] inst, input logic run);
        imem[wp] = inst;
        if (run) trace.push_back(32'(wp * 4));  // skipped slots never execute
        wp++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] up;
        up = v + 32'h800;                       // rounds for the signed addi part
        put({up[31:12], rd, 7'b0110111}, 1'b1);
        put(enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011), 1'b1);
        mreg[rd] = v;
    endtask

    task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        put(enc_r(f7, rs2, rs1, f3, rd), 1'b1);
        if (f7 == 7'd1) mreg[rd] = div_ref(f3, mreg[rs1], mreg[rs2]);
        else mreg[rd] = alu_ref(f3, f7[5], mreg[rs1], mreg[rs2]);
    endtask

    task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        put(enc_i(imm, rs1, f3, rd, 7'b0010011), 1'b1);
        mreg[rd] = alu_ref(f3, (f3 == 3'b101) & imm[10], mreg[rs1], {{20{imm[11]}}, imm});
    endtask

    task automatic store_check(input logic [4:0] rs, input string name);
        logic [31:0] addr;
        addr = STORE_BASE + 32'(4 * exp_val.size());
        put(enc_s(addr[11:0], rs), 1'b1);
        exp_val.push_back(mreg[rs]);
        exp_addr.push_back(addr);
        exp_name.push_back(name);
    endtask

    // branch over one addi to x30, then x30 shows the outcome
    task automatic branch_test(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2);
        logic tk;
        tk = taken_ref(f3, mreg[rs1], mreg[rs2]);
        put(enc_b(13'd8, rs2, rs1, f3), 1'b1);
        put(enc_i(12'd1, 5'd30, 3'b000, 5'd30, 7'b0010011), !tk);
        if (!tk) mreg[30] = mreg[30] + 1;
        store_check(5'd30, $sformatf("branch f3=%0d x%0d,x%0d", f3, rs1, rs2));
    endtask

    task automatic build_program();
        logic [31:0] pcv;
        logic [31:0] a;
        logic [19:0] up;
        for (int i = 0; i < 32; i++) mreg[i] = '0;
        load_const(5'd1, $random(seed) & 32'h7fff_ffff);
        load_const(5'd2, $random(seed) | 32'h8000_0000);
        for (int f3 = 0; f3 < 8; f3++) begin
            reg_op(7'd0, 3'(f3), 5'd8, 5'd1, 5'd2);
            store_check(5'd8, $sformatf("op f3=%0d", f3));
        end
        reg_op(7'h20, 3'b000, 5'd8, 5'd1, 5'd2);
        store_check(5'd8, "sub");
        reg_op(7'h20, 3'b101, 5'd8, 5'd2, 5'd1);
        store_check(5'd8, "sra");
        for (int f3 = 0; f3 < 8; f3++) begin
            a = $random(seed);
            if (f3 == 1) imm_op(3'(f3), 5'd9, 5'd2, {7'd0, a[4:0]});
            else if (f3 == 5) imm_op(3'(f3), 5'd9, 5'd2, {1'b0, a[0], 5'd0, a[4:0]});
            else imm_op(3'(f3), 5'd9, 5'd1, a[11:0]);
            store_check(5'd9, $sformatf("op-imm f3=%0d", f3));
        end
        up = 20'($random(seed));
        put({up, 5'd9, 7'b0110111}, 1'b1);
        mreg[9] = {up, 12'd0};
        store_check(5'd9, "lui");
        pcv = 32'(wp * 4);
        put({up, 5'd9, 7'b0010111}, 1'b1);
        mreg[9] = pcv + {up, 12'd0};
        store_check(5'd9, "auipc");
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) continue;
            branch_test(3'(f3), 5'd1, 5'd2);
            branch_test(3'(f3), 5'd2, 5'd1);
            branch_test(3'(f3), 5'd1, 5'd1);
        end
        pcv = 32'(wp * 4);
        put(enc_j(21'd8, 5'd5), 1'b1);
        put(enc_i(12'd1, 5'd30, 3'b000, 5'd30, 7'b0010011), 1'b0);
        mreg[5] = pcv + 4;
        store_check(5'd5, "jal link");
        store_check(5'd30, "jal skip");
        pcv = 32'((wp + 2) * 4);                // address of the jalr
        load_const(5'd6, pcv + 4);
        put(enc_i(12'd5, 5'd6, 3'b000, 5'd7, 7'b1100111), 1'b1);
        put(enc_i(12'd1, 5'd30, 3'b000, 5'd30, 7'b0010011), 1'b0);
        mreg[7] = pcv + 4;
        store_check(5'd7, "jalr link");
        store_check(5'd30, "jalr skip");
        load_const(5'd10, $random(seed));
        store_check(5'd10, "sw before lw");
        put(enc_i(exp_addr[exp_addr.size() - 1][11:0], 5'd0, 3'b010, 5'd11, 7'b0000011), 1'b1);
        mreg[11] = mreg[10];
        store_check(5'd11, "lw");
        for (int n = 0; n < 4; n++) begin
            load_const(5'd3, $random(seed));
            load_const(5'd4, (n == 3) ? 32'd0 : $random(seed) >>> (n * 8));
            for (int f3 = 4; f3 < 8; f3++) begin
                reg_op(7'd1, 3'(f3), 5'd12, 5'd3, 5'd4);
                store_check(5'd12, $sformatf("div f3=%0d set %0d", f3, n));
            end
        end
        reg_op(7'd1, 3'b100, 5'd13, 5'd2, 5'd1);   // back-to-back divides
        reg_op(7'd1, 3'b110, 5'd14, 5'd2, 5'd1);
        store_check(5'd13, "div pair first");
        store_check(5'd14, "rem pair second");
        halt_pc = 32'(wp * 4);
        put(enc_j(21'd0, 5'd0), 1'b1);          // parks the core
    endtask

    always @(negedge clk) begin
        if (clrn && !done) begin
            if (o_pc != last_pc) begin
                checks++;
                assert ((idx + 1 < trace.size()) && (o_pc == trace[idx + 1])) else begin
                    errors++;
                    $display("FAIL next_pc: expected %h, actual %h",
                             (idx + 1 < trace.size()) ? trace[idx + 1] : 32'hffff_ffff, o_pc);
                end
                if (last_was_div) begin
                    assert (stay >= `RV32_DIV_STEPS) else begin
                        errors++;
                        $display("divide at %h ended after only %0d cycles", last_pc, stay);
                    end
                end
                idx++;
                stay    = 0;
                last_pc = o_pc;
            end else begin
                stay++;
            end
            last_was_div = is_div(i_inst);
            if (!last_was_div && stay > 0 && o_pc != halt_pc) begin
                assert (0) else begin
                    errors++;
                    $display("instruction at %h held o_pc for more than one cycle", o_pc);
                end
            end
            if (o_pc == halt_pc) done = 1'b1;
            if (o_wmem) begin
                checks++;
                if (sidx < exp_val.size()) begin
                    assert (o_b == exp_val[sidx]) else begin
                        errors++;
                        $display("FAIL %s: expected %h, actual %h",
                                 exp_name[sidx], exp_val[sidx], o_b);
                    end
                    assert (o_alu_out == exp_addr[sidx]) else begin
                        errors++;
                        $display("FAIL %s address: expected %h, actual %h",
                                 exp_name[sidx], exp_addr[sidx], o_alu_out);
                    end
                end else begin
                    errors++;
                    $display("store at %h that the program does not contain", o_pc);
                end
                sidx++;
            end
        end
    end

    initial begin
        clk          = 1'b0;
        clrn         = 1'b0;
        seed         = 32'hf963;
        wp           = 0;
        idx          = 0;
        sidx         = 0;
        stay         = -1;
        errors       = 0;
        checks       = 0;
        last_pc      = `RV32_RESET_PC;
        last_was_div = 1'b0;
        done         = 1'b0;
        built        = 1'b0;
        for (int i = 0; i < 512; i++) imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011);
        for (int i = 0; i < 256; i++) dmem[i] = 32'hd00d_0000 ^ (i * 32'h0001_0203);
        build_program();
        built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        clrn <= 1'b1;
        wait (done);
        repeat (2) @(negedge clk);
        assert (sidx == exp_val.size()) else begin
            errors++;
            $display("only %0d of %0d stores reached the ports", sidx, exp_val.size());
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog sized from the executed instruction count
    initial begin
        wait (built);
        #((trace.size() * CYCLES_PER_INST + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: program did not reach its final instruction at %h", halt_pc);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: source/div_if.sv
`timescale 1ns/100ps
`include "rv32_cfg.svh"

// four-phase req/ack link between the core and the divider
interface div_if #(
    parameter int WIDTH = `RV32_XLEN
);
    logic             req;
    logic             ack;
    logic             is_signed;            // div, rem
    logic             want_rem;             // rem, remu
    logic [WIDTH-1:0] dividend;
    logic [WIDTH-1:0] divisor;
    logic [WIDTH-1:0] result;

    modport core (
        output req, is_signed, want_rem, dividend, divisor,
        input  ack, result
    );
    modport divider (
        input  req, is_signed, want_rem, dividend, divisor,
        output ack, result
    );
endinterface

// File: source/rv32_cfg.svh
`ifndef RV32_CFG_SVH
`define RV32_CFG_SVH

// data and address width
`define RV32_XLEN 32

// architectural registers, x0 included
`define RV32_NREGS 32

// fetch address after reset
`define RV32_RESET_PC 32'h0000_0000

// shift-subtract iterations of one divide
`define RV32_DIV_STEPS `RV32_XLEN

`endif

// File: source/rv32_core.sv
`timescale 1ns/100ps
`include "rv32_cfg.svh"

module rv32_core (
    input  logic        clk,
    input  logic        clrn,
    input  logic [31:0] i_inst,
    input  logic [31:0] i_mem,
    output logic [31:0] o_pc,
    output logic [31:0] o_alu_out,
    output logic [31:0] o_b,
    output logic        o_wmem
);
    import rv32_pkg::*;

    word_t      pc;
    word_t      next_pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    word_t      wdata;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       wreg;
    logic       load;
    logic       store;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       div;
    logic       div_signed;
    logic       div_rem;
    logic [2:0] br_funct;
    logic       div_rel;                    // release phase of the handshake
    logic       advance;                    // instruction retires this cycle

    div_if #(.WIDTH(`RV32_XLEN)) dif ();

    assign advance       = ~div | (dif.ack & ~div_rel);
    assign dif.req       = div & ~(div_rel & dif.ack);
    assign dif.is_signed = div_signed;
    assign dif.want_rem  = div_rem;
    assign dif.dividend  = rs1_data;
    assign dif.divisor   = rs2_data;

    assign o_pc      = pc;
    assign o_b       = rs2_data;            // store data
    assign o_wmem    = store;

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            pc      <= `RV32_RESET_PC;
            div_rel <= 1'b0;
        end else begin
            if (advance) pc <= next_pc;     // holds during a divide
            div_rel <= dif.ack;             // stays set until ack has fallen
        end
    end

    rv32_decode u_decode (
        .i_inst(i_inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_use_imm(use_imm), .o_wreg(wreg), .o_load(load),
        .o_store(store), .o_branch(branch), .o_jal(jal), .o_jalr(jalr), .o_div(div),
        .o_div_signed(div_signed), .o_div_rem(div_rem), .o_br_funct(br_funct)
    );

    rv32_regfile u_regfile (
        .clk(clk), .clrn(clrn), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_we(wreg & advance), .i_wdata(wdata),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv32_execute u_execute (
        .i_pc(pc), .i_a(rs1_data), .i_b(rs2_data), .i_imm(imm), .i_mem(i_mem),
        .i_div_result(dif.result), .i_alu_op(alu_op), .i_use_imm(use_imm),
        .i_load(load), .i_branch(branch), .i_jal(jal), .i_jalr(jalr), .i_div(div),
        .i_br_funct(br_funct), .o_alu_out(o_alu_out), .o_wdata(wdata),
        .o_next_pc(next_pc)
    );

    rv32_divider #(.WIDTH(`RV32_XLEN)) u_divider (
        .clk(clk), .clrn(clrn), .dif(dif.divider)
    );

    // no divide finishes before every step has run
    a_div_min: assert property (@(posedge clk) disable iff (!clrn)
        $rose(dif.req) |-> ##(`RV32_DIV_STEPS + 1) !dif.ack);

endmodule

// File: source/rv32_decode.sv
`timescale 1ns/100ps

module rv32_decode (
    input  rv32_pkg::word_t    i_inst,
    output rv32_pkg::reg_idx_t o_rs1,
    output rv32_pkg::reg_idx_t o_rs2,
    output rv32_pkg::reg_idx_t o_rd,
    output rv32_pkg::word_t    o_imm,
    output rv32_pkg::alu_op_t  o_alu_op,
    output logic               o_use_imm,
    output logic               o_wreg,
    output logic               o_load,
    output logic               o_store,
    output logic               o_branch,
    output logic               o_jal,
    output logic               o_jalr,
    output logic               o_div,
    output logic               o_div_signed,
    output logic               o_div_rem,
    output logic [2:0]         o_br_funct
);
    import rv32_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // funct3 to ALU op, alt picks sub or sra
    function automatic alu_op_t base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  base_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  base_op = ALU_SLL;
            3'b010:  base_op = ALU_SLT;
            3'b011:  base_op = ALU_SLTU;
            3'b100:  base_op = ALU_XOR;
            3'b101:  base_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  base_op = ALU_OR;
            default: base_op = ALU_AND;
        endcase
    endfunction

    assign opcode     = i_inst[6:0];
    assign funct3     = i_inst[14:12];
    assign funct7     = i_inst[31:25];
    assign o_rd       = i_inst[11:7];
    assign o_rs1      = i_inst[19:15];
    assign o_rs2      = i_inst[24:20];
    assign o_br_funct = funct3;

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};                        // lw, jalr, op-imm
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};          // sw
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};                                 // lui, auipc
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    always_comb begin
        o_imm        = imm_i;
        o_alu_op     = ALU_ADD;                 // also the lw/sw/jalr address
        o_use_imm    = 1'b0;
        o_wreg       = 1'b0;
        o_load       = 1'b0;
        o_store      = 1'b0;
        o_branch     = 1'b0;
        o_jal        = 1'b0;
        o_jalr       = 1'b0;
        o_div        = 1'b0;
        o_div_signed = 1'b0;
        o_div_rem    = 1'b0;
        case (opcode)
            OP_LUI, OP_AUIPC: begin
                o_imm     = imm_u;
                o_alu_op  = (opcode == OP_LUI) ? ALU_PASS_B : ALU_PC_ADD;
                o_use_imm = 1'b1;
                o_wreg    = 1'b1;
            end
            OP_JAL: begin
                o_imm  = imm_j;
                o_jal  = 1'b1;
                o_wreg = 1'b1;
            end
            OP_JALR: begin
                o_use_imm = 1'b1;
                o_jalr    = (funct3 == 3'b000);
                o_wreg    = (funct3 == 3'b000);
            end
            OP_BRANCH: begin
                o_imm    = imm_b;
                o_branch = (funct3[2:1] != 2'b01);  // 010 and 011 unused
            end
            OP_LOAD: begin
                o_use_imm = 1'b1;
                o_load    = (funct3 == 3'b010);     // lw only
                o_wreg    = (funct3 == 3'b010);
            end
            OP_STORE: begin
                o_imm     = imm_s;
                o_use_imm = 1'b1;
                o_store   = (funct3 == 3'b010);     // sw only
            end
            OP_IMM: begin
                o_use_imm = 1'b1;
                o_alu_op  = base_op(funct3, (funct3 == 3'b101) & funct7[5]);
                case (funct3)
                    3'b001:  o_wreg = (funct7 == 7'b0000000);
                    3'b101:  o_wreg = ({funct7[6], funct7[4:0]} == 6'b000000);
                    default: o_wreg = 1'b1;
                endcase
            end
            OP_REG: begin
                o_alu_op = base_op(funct3, funct7[5]);
                if (funct7 == 7'b0000001) begin
                    o_div        = funct3[2];        // mul group decodes to a no-op
                    o_wreg       = funct3[2];
                    o_div_signed = ~funct3[0];
                    o_div_rem    = funct3[1];
                end else if (funct7 == 7'b0100000) begin
                    o_wreg = (funct3 == 3'b000) || (funct3 == 3'b101);
                end else begin
                    o_wreg = (funct7 == 7'b0000000);
                end
            end
            default: ;                               // unsupported, writes nothing
        endcase
    end

    always_comb begin
        assert ($onehot0({o_load, o_store, o_branch, o_div}))
            else $error("decode selects more than one of load, store, branch, div");
    end

endmodule

// File: source/rv32_divider.sv
`timescale 1ns/100ps
`include "rv32_cfg.svh"

module rv32_divider #(
    parameter int WIDTH = `RV32_XLEN
) (
    input logic    clk,
    input logic    clrn,
    div_if.divider dif
);
    import rv32_pkg::*;

    localparam int CW = $clog2(WIDTH + 1);

    div_state_t       state;
    logic [CW-1:0]    cnt;                  // step counter
    logic [WIDTH-1:0] quo;                  // dividend shifts out, quotient shifts in
    logic [WIDTH-1:0] rem;                  // partial remainder
    logic [WIDTH-1:0] dvsr;
    logic [WIDTH:0]   trial;
    logic             a_neg;
    logic             b_neg;
    logic             neg_q;
    logic             neg_r;
    logic             sel_rem;

    assign a_neg = dif.is_signed & dif.dividend[WIDTH-1];
    assign b_neg = dif.is_signed & dif.divisor[WIDTH-1];
    assign trial = {rem, quo[WIDTH-1]} - {1'b0, dvsr};

    assign dif.ack    = (state == DIV_DONE);
    assign dif.result = sel_rem ? rem : quo;

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (dif.req) state <= DIV_LOAD;
                end
                DIV_LOAD: begin
                    state <= DIV_STEP;
                    cnt   <= '0;
                end
                DIV_STEP: begin
                    cnt <= cnt + CW'(1);
                    if (cnt == CW'(WIDTH - 1)) begin
                        state <= (neg_q | neg_r) ? DIV_FIX : DIV_DONE;
                    end
                end
                DIV_FIX:  state <= DIV_DONE;
                DIV_DONE: begin
                    if (!dif.req) state <= DIV_IDLE;  // release phase
                end
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_LOAD: begin
                quo     <= a_neg ? -dif.dividend : dif.dividend;   // magnitudes
                dvsr    <= b_neg ? -dif.divisor : dif.divisor;
                rem     <= '0;
                neg_q   <= (a_neg ^ b_neg) & (dif.divisor != '0);  // x/0 stays all ones
                neg_r   <= a_neg;
                sel_rem <= dif.want_rem;
            end
            DIV_STEP: begin
                quo <= {quo[WIDTH-2:0], ~trial[WIDTH]};
                if (!trial[WIDTH]) begin
                    rem <= trial[WIDTH-1:0];
                end else begin
                    rem <= {rem[WIDTH-2:0], quo[WIDTH-1]};         // restore, shifted
                end
            end
            DIV_FIX: begin
                if (neg_q) quo <= -quo;
                if (neg_r) rem <= -rem;
            end
            default: ;
        endcase
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!clrn)
        $rose(dif.ack) |-> dif.req);
    a_result_stable: assert property (@(posedge clk) disable iff (!clrn)
        dif.ack && $past(dif.ack) |-> $stable(dif.result));
    a_ack_release: assert property (@(posedge clk) disable iff (!clrn)
        $fell(dif.ack) |-> $past(!dif.req));

endmodule

// File: source/rv32_execute.sv
`timescale 1ns/100ps

module rv32_execute (
    input  rv32_pkg::word_t   i_pc,
    input  rv32_pkg::word_t   i_a,
    input  rv32_pkg::word_t   i_b,
    input  rv32_pkg::word_t   i_imm,
    input  rv32_pkg::word_t   i_mem,
    input  rv32_pkg::word_t   i_div_result,
    input  rv32_pkg::alu_op_t i_alu_op,
    input  logic              i_use_imm,
    input  logic              i_load,
    input  logic              i_branch,
    input  logic              i_jal,
    input  logic              i_jalr,
    input  logic              i_div,
    input  logic [2:0]        i_br_funct,
    output rv32_pkg::word_t   o_alu_out,
    output rv32_pkg::word_t   o_wdata,
    output rv32_pkg::word_t   o_next_pc
);
    import rv32_pkg::*;

    word_t op_b;
    word_t pc_plus_4;
    word_t target;
    logic  taken;

    assign op_b      = i_use_imm ? i_imm : i_b;
    assign pc_plus_4 = i_pc + word_t'(4);
    assign target    = i_pc + i_imm;         // branch and jal

    always_comb begin
        case (i_alu_op)
            ALU_ADD:    o_alu_out = i_a + op_b;
            ALU_SUB:    o_alu_out = i_a - op_b;
            ALU_AND:    o_alu_out = i_a & op_b;
            ALU_OR:     o_alu_out = i_a | op_b;
            ALU_XOR:    o_alu_out = i_a ^ op_b;
            ALU_SLL:    o_alu_out = i_a << op_b[4:0];
            ALU_SRL:    o_alu_out = i_a >> op_b[4:0];
            ALU_SRA:    o_alu_out = word_t'($signed(i_a) >>> op_b[4:0]);
            ALU_SLT:    o_alu_out = word_t'($signed(i_a) < $signed(op_b));
            ALU_SLTU:   o_alu_out = word_t'(i_a < op_b);
            ALU_PASS_B: o_alu_out = op_b;
            ALU_PC_ADD: o_alu_out = i_pc + op_b;
            default:    o_alu_out = i_a + op_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (i_br_funct)
            3'b000:  taken = (i_a == i_b);
            3'b001:  taken = (i_a != i_b);
            3'b100:  taken = ($signed(i_a) < $signed(i_b));
            3'b101:  taken = ($signed(i_a) >= $signed(i_b));
            3'b110:  taken = (i_a < i_b);
            3'b111:  taken = (i_a >= i_b);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (i_jalr) begin
            o_next_pc = o_alu_out & ~word_t'(1);     // rs1 + imm, bit 0 cleared
        end else if (i_jal || (i_branch && taken)) begin
            o_next_pc = target;
        end else begin
            o_next_pc = pc_plus_4;
        end
    end

    // write-back source
    always_comb begin
        if (i_load) begin
            o_wdata = i_mem;
        end else if (i_div) begin
            o_wdata = i_div_result;
        end else if (i_jal || i_jalr) begin
            o_wdata = pc_plus_4;                   // link
        end else begin
            o_wdata = o_alu_out;
        end
    end

endmodule

// File: source/rv32_pkg.sv
`include "rv32_cfg.svh"

package rv32_pkg;

    typedef logic [`RV32_XLEN-1:0] word_t;      // data word
    typedef logic [4:0]            reg_idx_t;   // register number
    typedef logic [6:0]            opcode_t;    // major opcode field

    // major opcodes of the supported subset
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU,
        ALU_PASS_B,                             // lui
        ALU_PC_ADD                              // auipc
    } alu_op_t;

    typedef enum logic [2:0] {
        DIV_IDLE,
        DIV_LOAD,
        DIV_STEP,
        DIV_FIX,
        DIV_DONE
    } div_state_t;

endpackage

// File: source/rv32_regfile.sv
`timescale 1ns/100ps
`include "rv32_cfg.svh"

module rv32_regfile (
    input  logic               clk,
    input  logic               clrn,
    input  rv32_pkg::reg_idx_t i_rs1,
    input  rv32_pkg::reg_idx_t i_rs2,
    input  rv32_pkg::reg_idx_t i_rd,
    input  logic               i_we,
    input  rv32_pkg::word_t    i_wdata,
    output rv32_pkg::word_t    o_rs1_data,
    output rv32_pkg::word_t    o_rs2_data
);
    import rv32_pkg::*;

    word_t regs [1:`RV32_NREGS-1];               // x1..x31, x0 is not stored

    // x0 always reads zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            for (int i = 1; i < `RV32_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;               // x0 writes dropped
        end
    end

endmodule
